// File: sources.f
logic/scan_pkg.sv
logic/window_loader.sv
logic/char_lane.sv
logic/match_reducer.sv
logic/scan_controller.sv
logic/regex_scan_top.sv
verif/scan_memory_model.sv
verif/tb_regex_scan.sv

// File: verif/tb_regex_scan.sv
`timescale 1ns/1ps

module tb_regex_scan;
    import scan_pkg::*;

    localparam int MEMORY_ADDR_WIDTH = 11;
    localparam int PTR_WIDTH = 32;
    localparam int MEM_BYTES = (2 ** MEMORY_ADDR_WIDTH) * CHARS_PER_WORD;
    localparam int RANDOM_TESTS = 50;
    localparam int MAX_RAND_LEN = 64;
    // upper bound for the characters of all directed scans
    localparam int DIRECTED_CHARS = 400;
    localparam int CYCLES_PER_CHAR = 40;
    localparam int WATCHDOG_CYCLES = CYCLES_PER_CHAR * (DIRECTED_CHARS
        + RANDOM_TESTS * MAX_RAND_LEN) + 200 * (RANDOM_TESTS + 20);

    logic clk;
    logic rst;
    logic valid;
    logic ready;
    logic [PTR_WIDTH-1:0] start_ptr;
    logic [PTR_WIDTH-1:0] end_ptr;
    logic [CHAR_WIDTH-1:0] target;
    logic memory_valid;
    logic [MEMORY_ADDR_WIDTH-1:0] memory_addr;
    logic memory_ready;
    mem_word_u memory_data;
    logic done;
    logic accept;
    logic error;
    logic [PTR_WIDTH-1:0] match_pos;
    logic stall_en;

    // reference copy of the string memory
    logic [CHAR_WIDTH-1:0] text [MEM_BYTES];
    string test_name;
    bit exp_accept;
    int exp_pos;
    int results_seen;
    integer seed;

    regex_scan_top #(
        .MEMORY_ADDR_WIDTH (MEMORY_ADDR_WIDTH),
        .PTR_WIDTH         (PTR_WIDTH)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .ready        (ready),
        .start_ptr    (start_ptr),
        .end_ptr      (end_ptr),
        .target       (target),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .memory_ready (memory_ready),
        .memory_data  (memory_data),
        .done         (done),
        .accept       (accept),
        .error        (error),
        .match_pos    (match_pos)
    );

    scan_memory_model #(
        .MEMORY_ADDR_WIDTH (MEMORY_ADDR_WIDTH),
        .SEED              (96380)
    ) u_mem (
        .clk          (clk),
        .stall_en     (stall_en),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .memory_ready (memory_ready),
        .memory_data  (memory_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input int expected, input int actual);
        stop_run($sformatf("FAIL %s: expected %0d, actual %0d", name, expected, actual));
    endtask

    // first occurrence of tgt among pointers start up to stop-1
    function automatic void ref_scan(input int start, input int stop,
                                     input logic [CHAR_WIDTH-1:0] tgt,
                                     output bit hit, output int pos);
        hit = 1'b0;
        pos = 0;
        for (int p = start; p < stop; p++)
        begin
            if (!hit && text[p] == tgt)
            begin
                hit = 1'b1;
                pos = p;
            end
        end
    endfunction

    task automatic write_byte(input int addr, input logic [CHAR_WIDTH-1:0] value);
        text[addr] = value;
        u_mem.mem_bytes[addr] = value;
    endtask

    // lower case letters only, mixed from every address bit
    task automatic fill_memory();
        for (int a = 0; a < MEM_BYTES; a++)
        begin
            write_byte(a, 8'h61 + 8'(((a ^ (a >> 5)) * 7) % 26));
        end
    endtask

    task automatic check_reset_state();
        assert (!done && !accept && !error && !memory_valid)
            else stop_run("outputs not cleared after reset");
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    // stall switch changes away from the falling edge the memory samples on
    task automatic set_stalls(input bit on);
        @(posedge clk);
        stall_en = on;
        @(negedge clk);
    endtask

    task automatic run_scan(input string name, input int start, input int stop,
                            input logic [CHAR_WIDTH-1:0] tgt);
        bit hit;
        int pos;
        int cycles;
        int limit;
        int seen_before;
        ref_scan(start, stop, tgt, hit, pos);
        test_name = name;
        exp_accept = hit;
        exp_pos = pos;
        seen_before = results_seen;
        limit = CYCLES_PER_CHAR * (stop - start + LANES) + 20;
        start_ptr = start;
        end_ptr = stop;
        target = tgt;
        valid = 1'b1;
        // handshake is judged at the rising edge, as the DUT sees it
        cycles = 0;
        @(posedge clk);
        while (!ready && cycles < 1000)
        begin
            @(posedge clk);
            cycles++;
        end
        assert (ready) else stop_run($sformatf("request of %s never accepted", name));
        @(negedge clk);
        valid = 1'b0;
        cycles = 0;
        while (!done && !error && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (!error) else stop_run($sformatf("error raised on aligned request %s", name));
        assert (done) else stop_run($sformatf("timeout waiting for done in %s", name));
        @(negedge clk);
        assert (!done) else stop_run($sformatf("done longer than one cycle in %s", name));
        assert (results_seen == seen_before + 1)
            else stop_run($sformatf("result of %s not compared exactly once", name));
    endtask

    task automatic run_random_tests();
        int start;
        int len;
        logic [CHAR_WIDTH-1:0] tgt;
        for (int n = 0; n < RANDOM_TESTS; n++)
        begin
            start = (($random(seed) & 32'h7fffffff) % 3900) * LANES;
            len = ($random(seed) & 32'h7fffffff) % (MAX_RAND_LEN + 1);
            // small alphabet, also past the end so read-ahead sees data
            for (int p = start; p < start + len + 8; p++)
            begin
                write_byte(p, 8'h61 + 8'(($random(seed) & 32'h7fffffff) % 8));
            end
            tgt = 8'h61 + 8'(($random(seed) & 32'h7fffffff) % 12);
            run_scan($sformatf("random_%0d", n), start, start + len, tgt);
        end
    endtask

    task automatic run_misaligned(input int start);
        int cycles;
        test_name = "misaligned_start";
        start_ptr = start;
        end_ptr = start + 16;
        valid = 1'b1;
        cycles = 0;
        while (!error && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (error) else stop_run("error not raised for a misaligned start");
        valid = 1'b0;
        repeat (8)
        begin
            @(negedge clk);
            assert (error && !done && !accept)
                else stop_run("error dropped, or done or accept seen after misaligned start");
        end
        apply_reset();
        check_reset_state();
    endtask

    // result compare, sampled on the falling edge where done is settled
    always @(negedge clk)
    begin
        if (!rst && done)
        begin
            results_seen++;
            assert (accept == exp_accept) else report_value(test_name, exp_accept, accept);
            if (accept)
            begin
                assert (match_pos == exp_pos) else report_value(test_name, exp_pos, match_pos);
            end
        end
    end

    initial
    begin
        seed = 96380;
        rst = 1'b1;
        valid = 1'b0;
        start_ptr = '0;
        end_ptr = '0;
        target = '0;
        stall_en = 1'b0;
        results_seen = 0;
        exp_accept = 1'b0;
        exp_pos = 0;
        test_name = "reset";
        fill_memory();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_reset_state();

        // hits inside the first window
        write_byte(66, "X");
        run_scan("first_window_hit", 64, 96, "X");
        write_byte(67, "W");
        run_scan("first_window_last_lane", 64, 96, "W");

        // hit from a buffer refill, then one several words out
        write_byte(134, "K");
        run_scan("buffer_refill_hit", 128, 200, "K");
        write_byte(157, "Q");
        write_byte(190, "Q");
        run_scan("word_fetch_hit", 128, 200, "Q");

        // target missing, or only at and after end_ptr
        run_scan("target_absent", 256, 300, "Z");
        write_byte(340, "Y");
        write_byte(345, "Y");
        run_scan("target_past_end", 320, 340, "Y");

        set_stalls(1'b1);
        run_random_tests();
        set_stalls(1'b0);

        run_misaligned(514);

        // empty string right after the error reset
        run_scan("zero_length", 400, 400, text[400]);

        $display("=== PASS ===");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_run("watchdog expired before all tests finished");
    end

endmodule

// File: verif/scan_memory_model.sv
`timescale 1ns/1ps

module scan_memory_model #(
    parameter int MEMORY_ADDR_WIDTH = 11,
    parameter int SEED = 96380
) (
    input  logic                          clk,
    input  logic                          stall_en,
    input  logic                          memory_valid,
    input  logic [MEMORY_ADDR_WIDTH-1:0]  memory_addr,
    output logic                          memory_ready,
    output scan_pkg::mem_word_u           memory_data
);
    import scan_pkg::*;

    localparam int MEM_BYTES = (2 ** MEMORY_ADDR_WIDTH) * CHARS_PER_WORD;

    // byte image of the string memory, written by the testbench
    logic [CHAR_WIDTH-1:0] mem_bytes [MEM_BYTES];
    integer stall_seed;

    initial
    begin
        stall_seed = SEED;
        memory_ready = 1'b1;
        memory_data = '0;
    end

    // ready moves on the falling edge, low about one cycle in four when stalling
    always @(negedge clk)
    begin
        if (stall_en)
        begin
            memory_ready <= (($random(stall_seed) & 3) != 0);
        end
        else
        begin
            memory_ready <= 1'b1;
        end
    end

    // accepted read shows up one cycle later and is held until the next one
    // character k of a word sits in byte lane k
    always @(posedge clk)
    begin
        if (memory_valid && memory_ready)
        begin
            for (int k = 0; k < CHARS_PER_WORD; k++)
            begin
                memory_data.chars[k] <= mem_bytes[int'(memory_addr) * CHARS_PER_WORD + k];
            end
        end
    end

endmodule

// File: logic/regex_scan_top.sv
`timescale 1ns/1ps

module regex_scan_top #(
    parameter int MEMORY_ADDR_WIDTH = 11,
    parameter int PTR_WIDTH = 32
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             valid,
    output logic                             ready,
    input  logic [PTR_WIDTH-1:0]             start_ptr,
    input  logic [PTR_WIDTH-1:0]             end_ptr,
    // compared live by the lanes, held by the requester until done
    input  logic [scan_pkg::CHAR_WIDTH-1:0]  target,
    output logic                             memory_valid,
    output logic [MEMORY_ADDR_WIDTH-1:0]     memory_addr,
    input  logic                             memory_ready,
    input  scan_pkg::mem_word_u              memory_data,
    output logic                             done,
    output logic                             accept,
    output logic                             error,
    output logic [PTR_WIDTH-1:0]             match_pos
);
    import scan_pkg::*;

    logic load_first;
    logic advance;
    logic req_first;
    logic need_word;
    logic word_granted;
    logic found;
    logic at_end;
    logic [PTR_WIDTH-1:0] cur_ptr;
    logic [LANES-1:0] lane_we;
    logic [LANES-1:0] first_sel;
    lane_slot_t lane_slot [LANES];
    lane_status_t lane_status [LANES];

    scan_controller #(
        .PTR_WIDTH (PTR_WIDTH)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .start_ptr    (start_ptr),
        .memory_ready (memory_ready),
        .need_word    (need_word),
        .word_granted (word_granted),
        .found        (found),
        .at_end       (at_end),
        .ready        (ready),
        .load_first   (load_first),
        .advance      (advance),
        .req_first    (req_first),
        .done         (done),
        .accept       (accept),
        .error        (error)
    );

    window_loader #(
        .MEMORY_ADDR_WIDTH (MEMORY_ADDR_WIDTH),
        .PTR_WIDTH         (PTR_WIDTH)
    ) u_loader (
        .clk          (clk),
        .rst          (rst),
        .start_ptr    (start_ptr),
        .end_ptr      (end_ptr),
        .req_first    (req_first),
        .load_first   (load_first),
        .advance      (advance),
        .memory_ready (memory_ready),
        .memory_data  (memory_data),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .need_word    (need_word),
        .word_granted (word_granted),
        .cur_ptr      (cur_ptr),
        .lane_we      (lane_we),
        .lane_slot    (lane_slot),
        .first_sel    (first_sel)
    );

    // one slot per window character, flushed on completion
    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        char_lane u_lane (
            .clk      (clk),
            .rst      (rst),
            .flush    (done),
            .we       (lane_we[i]),
            .slot_in  (lane_slot[i]),
            .is_first (first_sel[i]),
            .target   (target),
            .status   (lane_status[i])
        );
    end

    match_reducer #(
        .PTR_WIDTH (PTR_WIDTH)
    ) u_reduce (
        .clk         (clk),
        .rst         (rst),
        .lane_status (lane_status),
        .cur_ptr     (cur_ptr),
        .found       (found),
        .at_end      (at_end),
        .match_pos   (match_pos)
    );

endmodule

// File: logic/scan_controller.sv
`timescale 1ns/1ps

module scan_controller #(
    parameter int PTR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid,
    input  logic [PTR_WIDTH-1:0]  start_ptr,
    input  logic                  memory_ready,
    input  logic                  need_word,
    input  logic                  word_granted,
    input  logic                  found,
    input  logic                  at_end,
    output logic                  ready,
    output logic                  load_first,
    output logic                  advance,
    output logic                  req_first,
    output logic                  done,
    output logic                  accept,
    output logic                  error
);
    import scan_pkg::*;

    scan_state_e state;
    scan_state_e next_state;
    logic aligned;

    // window loads in one piece only from a lane 0 start
    assign aligned = (start_ptr[LANE_ID_BITS-1:0] == '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    assign ready = (state == IDLE) & memory_ready;
    assign req_first = (state == IDLE) & valid & aligned;
    assign load_first = (state == FETCH_FIRST);
    // step on when nothing decided and the next character is reachable
    assign advance = (state == EXE) & !found & !at_end & (!need_word | word_granted);
    assign done = (state == DONE_ACCEPT) | (state == DONE_REJECT);
    assign accept = (state == DONE_ACCEPT);
    assign error = (state == ERROR);

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (valid && !aligned)
                begin
                    next_state = ERROR;
                end
                else if (valid && memory_ready)
                begin
                    next_state = FETCH_FIRST;
                end
            end
            FETCH_FIRST:
            begin
                next_state = EXE;
            end
            EXE:
            begin
                // hit beats end, end beats stepping on
                if (found)
                begin
                    next_state = DONE_ACCEPT;
                end
                else if (at_end)
                begin
                    next_state = DONE_REJECT;
                end
                else if (advance)
                begin
                    next_state = need_word ? FETCH_WORD : FETCH_BUFFER;
                end
            end
            FETCH_WORD, FETCH_BUFFER:
            begin
                next_state = EXE;
            end
            DONE_ACCEPT, DONE_REJECT:
            begin
                next_state = IDLE;
            end
            ERROR:
            begin
                // held until reset
                next_state = ERROR;
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    // once in ERROR the FSM stays there and never reports done
    a_done_not_error: assert property (@(posedge clk) disable iff (rst)
        error |=> (error && !done));
    // accept only follows a hit judged in the cycle before
    a_accept_with_done: assert property (@(posedge clk) disable iff (rst)
        accept |-> (done && $past(found)));

endmodule

// File: logic/match_reducer.sv
`timescale 1ns/1ps

module match_reducer #(
    parameter int PTR_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  scan_pkg::lane_status_t  lane_status [scan_pkg::LANES],
    input  logic [PTR_WIDTH-1:0]    cur_ptr,
    output logic                    found,
    output logic                    at_end,
    output logic [PTR_WIDTH-1:0]    match_pos
);
    import scan_pkg::*;

    logic [LANES-1:0] hits;
    logic [LANES-1:0] ends;

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            hits[i] = lane_status[i].hit;
            ends[i] = lane_status[i].at_end;
        end
    end

    assign found = |hits;
    assign at_end = |ends;

    // cur_ptr names the judged character, so it is the match position
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            match_pos <= '0;
        end
        else if (found)
        begin
            match_pos <= cur_ptr;
        end
    end

    // one-hot first_sel across the lanes keeps hits exclusive
    a_single_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hits));

endmodule

// File: logic/char_lane.sv
`timescale 1ns/1ps

module char_lane (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             flush,
    input  logic                             we,
    input  scan_pkg::lane_slot_t             slot_in,
    input  logic                             is_first,
    input  logic [scan_pkg::CHAR_WIDTH-1:0]  target,
    output scan_pkg::lane_status_t           status
);
    import scan_pkg::*;

    lane_slot_t slot_q;

    // slot is emptied after every completed scan
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            slot_q <= '0;
        end
        else if (we)
        begin
            slot_q <= slot_in;
        end
    end

    // only the slot under judgement may report
    // characters past end_ptr are never valid, so they cannot hit
    assign status.hit = slot_q.valid & is_first & (slot_q.ch == target);
    assign status.at_end = is_first & slot_q.end_of_s;

endmodule

// File: logic/window_loader.sv
`timescale 1ns/1ps

module window_loader #(
    parameter int MEMORY_ADDR_WIDTH = 11,
    parameter int PTR_WIDTH = 32
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [PTR_WIDTH-1:0]               start_ptr,
    input  logic [PTR_WIDTH-1:0]               end_ptr,
    input  logic                               req_first,
    input  logic                               load_first,
    input  logic                               advance,
    input  logic                               memory_ready,
    input  scan_pkg::mem_word_u                memory_data,
    output logic                               memory_valid,
    output logic [MEMORY_ADDR_WIDTH-1:0]       memory_addr,
    output logic                               need_word,
    output logic                               word_granted,
    output logic [PTR_WIDTH-1:0]               cur_ptr,
    output logic [scan_pkg::LANES-1:0]         lane_we,
    output scan_pkg::lane_slot_t               lane_slot [scan_pkg::LANES],
    output logic [scan_pkg::LANES-1:0]         first_sel
);
    import scan_pkg::*;

    // request bounds, captured while IDLE offers a request
    logic [PTR_WIDTH-1:0] start_q;
    logic [PTR_WIDTH-1:0] end_q;
    // read-ahead pointer, next character to be written into the window
    logic [PTR_WIDTH-1:0] rd_ptr;
    mem_word_u buffer;
    // a refill is due this cycle, and whether it comes from memory
    logic pend;
    logic pend_word;
    mem_word_u src_word;
    logic [CHAR_WIDTH-1:0] new_char;

    always_ff @(posedge clk)
    begin
        if (req_first)
        begin
            start_q <= start_ptr;
            end_q <= end_ptr;
        end
    end

    // next character opens a new word when its offset wraps to zero
    assign need_word = (rd_ptr[WORD_OFFSET_BITS-1:0] == '0);
    assign word_granted = need_word & memory_ready;

    // first word in IDLE, then one word read per crossed word boundary
    assign memory_valid = req_first | (advance & need_word);
    assign memory_addr = req_first ? start_ptr[WORD_OFFSET_BITS +: MEMORY_ADDR_WIDTH]
                                   : rd_ptr[WORD_OFFSET_BITS +: MEMORY_ADDR_WIDTH];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_ptr <= '0;
            cur_ptr <= '0;
            first_sel <= '0;
            pend <= 1'b0;
            pend_word <= 1'b0;
        end
        else
        begin
            pend <= advance;
            pend_word <= advance & need_word;
            if (load_first)
            begin
                // aligned start always lands on lane 0
                cur_ptr <= start_q;
                rd_ptr <= start_q + PTR_WIDTH'(LANES);
                first_sel <= {{(LANES-1){1'b0}}, 1'b1};
            end
            else
            begin
                if (advance)
                begin
                    cur_ptr <= cur_ptr + 1'b1;
                    first_sel <= {first_sel[LANES-2:0], first_sel[LANES-1]};
                end
                if (pend)
                begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // the buffer tracks the word that rd_ptr currently reads from
    always_ff @(posedge clk)
    begin
        if (load_first || pend_word)
        begin
            buffer <= memory_data;
        end
    end

    // fresh word straight from memory, else the buffered one
    assign src_word = pend_word ? memory_data : buffer;
    assign new_char = src_word.chars[rd_ptr[WORD_OFFSET_BITS-1:0]];

    always_comb
    begin
        logic [PTR_WIDTH-1:0] slot_ptr;
        for (int i = 0; i < LANES; i++)
        begin
            if (load_first)
            begin
                slot_ptr = start_q + PTR_WIDTH'(i);
                lane_slot[i].ch = memory_data.windows[start_q[WORD_OFFSET_BITS-1]][i];
            end
            else
            begin
                slot_ptr = rd_ptr;
                lane_slot[i].ch = new_char;
            end
            lane_slot[i].valid = (slot_ptr < end_q);
            lane_slot[i].end_of_s = !(slot_ptr < end_q);
        end
    end

    // whole window on the first load, then the lane freed by the last advance
    always_comb
    begin
        lane_we = '0;
        if (load_first)
        begin
            lane_we = '1;
        end
        else if (pend)
        begin
            lane_we[rd_ptr[LANE_ID_BITS-1:0]] = 1'b1;
        end
    end

    // refill must land behind the rotated judgement point
    a_refill_not_judged: assert property (@(posedge clk) disable iff (rst)
        pend |-> ((lane_we & first_sel) == '0));

endmodule

// File: logic/scan_pkg.sv
package scan_pkg;

    // character and window geometry
    localparam int CHAR_WIDTH = 8;
    localparam int LANES = 4;
    localparam int LANE_ID_BITS = 2;

    // memory word geometry
    localparam int WORD_WIDTH = 64;
    localparam int CHARS_PER_WORD = 8;
    localparam int WORD_OFFSET_BITS = 3;

    // one memory word, seen as single characters for refills
    // or as two aligned windows for the first load
    typedef union packed {
        logic [CHARS_PER_WORD-1:0][CHAR_WIDTH-1:0] chars;
        logic [WORD_WIDTH/(LANES*CHAR_WIDTH)-1:0][LANES-1:0][CHAR_WIDTH-1:0] windows;
    } mem_word_u;

    // what the loader writes into a window slot
    typedef struct packed {
        logic [CHAR_WIDTH-1:0] ch;
        // character lies inside the string
        logic valid;
        // character sits at or past end_ptr
        logic end_of_s;
    } lane_slot_t;

    // per slot verdict, only meaningful for the slot under judgement
    typedef struct packed {
        logic hit;
        logic at_end;
    } lane_status_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_FIRST,
        EXE,
        FETCH_WORD,
        FETCH_BUFFER,
        DONE_ACCEPT,
        DONE_REJECT,
        ERROR
    } scan_state_e;

endpackage
